//--- sim/exe_testdata.hex
// grp ctl fn rd aluOp mOp opA opB pc bImm jImm sImm, then expected aluRes target memOut misaligned
// all hex; ctl = {we,bneq,btype,j,jr}; group 2 replaces opA and opB with random values
1 10 0 01 0 0 fffffffe 3 100 0 0 0 1 104 0 0
1 10 1 02 1 0 5 7 100 0 0 0 fffffffe 104 0 0
1 10 2 03 2 0 1 24 100 0 0 0 10 104 0 0
1 10 3 04 3 0 ffffffff 1 100 0 0 0 1 104 0 0
1 10 4 05 4 0 ffffffff 1 100 0 0 0 0 104 0 0
1 10 5 06 5 0 f0f0 ff00 100 0 0 0 ff0 104 0 0
1 10 6 07 6 0 80000000 4 100 0 0 0 8000000 104 0 0
1 10 7 08 7 0 80000000 4 100 0 0 0 f8000000 104 0 0
1 10 0 09 8 0 f0 f 100 0 0 0 ff 104 0 0
1 10 1 0a 9 0 f0 3c 100 0 0 0 30 104 0 0
1 00 2 1f a 0 1234 abcd0000 100 0 0 0 abcd0000 104 0 0
2 10 0 0b 0 0 0 0 200 0 0 0 0 204 0 0
2 10 1 0c 1 0 0 0 200 0 0 0 0 204 0 0
2 10 2 0d 3 0 0 0 200 0 0 0 0 204 0 0
2 10 3 0e 4 0 0 0 200 0 0 0 0 204 0 0
2 10 4 0f 7 0 0 0 200 0 0 0 0 204 0 0
2 10 5 10 2 0 0 0 200 0 0 0 0 204 0 0
3 04 0 00 1 0 7 7 300 40 0 0 0 340 0 0
3 04 0 00 1 0 7 8 300 40 0 0 ffffffff 304 0 0
3 0c 0 00 1 0 7 7 300 fffffff0 0 0 0 304 0 0
3 0c 0 00 1 0 9 7 300 fffffff0 0 0 2 2f0 0 0
4 12 0 01 0 0 0 0 400 0 100 0 0 500 0 0
4 11 0 01 0 0 1001 22 400 0 0 0 1023 1022 0 0
4 17 0 01 1 0 500 500 400 40 100 0 0 a00 0 0
4 16 0 01 1 0 3 3 400 40 20 0 0 420 0 0
5 00 2 00 0 2 30 8899aabb 500 0 0 10 8899aaeb 504 0 0
5 10 2 01 0 1 40 0 500 0 0 0 40 504 8899aabb 0
5 00 0 00 0 2 40 f1 500 0 0 5 131 504 0 0
5 10 0 02 0 1 40 5 500 0 0 0 45 504 fffffff1 0
5 10 4 03 0 1 40 5 500 0 0 0 45 504 f1 0
5 00 1 00 0 2 48 12348765 500 0 0 2 123487ad 504 0 0
5 10 1 04 0 1 48 2 500 0 0 0 4a 504 ffff8765 0
5 10 5 05 0 1 48 2 500 0 0 0 4a 504 8765 0
5 10 0 06 0 1 40 3 500 0 0 0 43 504 ffffff88 0
5 10 5 07 0 1 40 2 500 0 0 0 42 504 8899 0
5 00 0 00 0 2 41 5a 500 0 0 0 9b 504 0 0
5 10 2 08 0 1 40 0 500 0 0 0 40 504 88995abb 0
6 00 2 00 0 2 40 deadbeef 600 0 0 2 deadbf2f 604 0 1
6 10 2 01 0 1 40 1 600 0 0 0 41 604 0 1
6 00 1 00 0 2 40 ffff 600 0 0 3 1003f 604 0 1
6 10 1 02 0 1 44 1 600 0 0 0 45 604 0 1
6 10 2 03 0 1 40 0 600 0 0 0 40 604 88995abb 0

//--- files.f
rtl/exePkg.sv
rtl/alu.sv
rtl/branchUnit.sv
rtl/memWrap.sv
rtl/exeStage.sv
sim/exeStage_checker.sv
sim/exeMonitor.sv
sim/exeStageTb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert --timescale 1ns/1ps
TOP       = exeStageTb
FILELIST  = files.f

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := obj_dir/V$(TOP)
LOG  := sim.log

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- sim/exeStageTb.sv
`default_nettype none

module exeStageTb;

    timeunit 1ns;
    timeprecision 1ps;

    logic               clk = 1'b0;
    logic               nrst;
    exePkg::issueBundle issue;
    exePkg::exeBundle   exe;
    exePkg::word        target;
    exePkg::word        memOut;
    logic               addrMisaligned;

    // expected values handed to the monitor with each record
    logic               chkValid;
    logic [3:0]         group;
    exePkg::word        expAlu;
    exePkg::word        expTgt;
    exePkg::word        expMem;
    logic               expMis;
    logic               done;
    logic               busy;
    logic               reported;
    int                 errors;
    int                 tests;

    always #2 clk = ~clk;

    initial
    begin
        nrst = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        nrst = 1'b1;
    end

    exeStage uut
    (
        .clk            (clk),
        .nrst           (nrst),
        .issue          (issue),
        .exe            (exe),
        .target         (target),
        .memOut         (memOut),
        .addrMisaligned (addrMisaligned)
    );

    exeMonitor mon
    (
        .clk            (clk),
        .chkValid       (chkValid),
        .group          (group),
        .stim           (issue),
        .expAlu         (expAlu),
        .expTgt         (expTgt),
        .expMem         (expMem),
        .expMis         (expMis),
        .exe            (exe),
        .target         (target),
        .memOut         (memOut),
        .addrMisaligned (addrMisaligned),
        .done           (done),
        .busy           (busy),
        .reported       (reported),
        .errors         (errors),
        .tests          (tests)
    );

    initial
    begin
        int          fd;
        int          n;
        int          waited;
        logic        ok;
        string       line;
        logic [3:0]  grpF;
        logic [4:0]  ctl;               // {we, bneq, btype, j, jr}
        logic [2:0]  fnF;
        logic [4:0]  rdF;
        logic [3:0]  opF;
        logic [1:0]  mopF;
        exePkg::word opA;
        exePkg::word opB;
        exePkg::word pcF;
        exePkg::word bImm;
        exePkg::word jImm;
        exePkg::word sImm;
        exePkg::word eAlu;
        exePkg::word eTgt;
        exePkg::word eMem;
        logic        eMis;

        issue    = '0;
        chkValid = 1'b0;
        group    = '0;
        expAlu   = '0;
        expTgt   = '0;
        expMem   = '0;
        expMis   = 1'b0;
        done     = 1'b0;
        ok       = 1'b1;
        void'($urandom(21261));

        waited = 0;
        while (nrst !== 1'b1 && waited < 40)
        begin
            @(negedge clk);
            waited++;
        end
        if (nrst !== 1'b1)
        begin
            $display("Timeout while waiting for reset release");
            ok = 1'b0;
        end

        fd = $fopen("sim/exe_testdata.hex", "r");
        if (fd == 0)
        begin
            $display("Could not open the testdata file");
            ok = 1'b0;
        end

        while (ok && !$feof(fd))
        begin
            line = "";
            n = $fgets(line, fd);
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        grpF, ctl, fnF, rdF, opF, mopF, opA, opB, pcF,
                        bImm, jImm, sImm, eAlu, eTgt, eMem, eMis);
            if (n == 16)                // comment and empty lines fall through
            begin
                @(negedge clk);
                issue          = '0;
                issue.we       = ctl[4];
                issue.bneq     = ctl[3];
                issue.btype    = ctl[2];
                issue.j        = ctl[1];
                issue.jr       = ctl[0];
                issue.fn       = fnF;
                issue.rd       = rdF;
                issue.aluOp    = exePkg::aluFn'(opF);
                issue.mOp      = exePkg::memOp'(mopF);
                issue.pcselect = grpF[1:0];     // pass-through field varies per group
                issue.opA      = (grpF == 4'd2) ? $urandom : opA;  // group 2 is random alu
                issue.opB      = (grpF == 4'd2) ? $urandom : opB;
                issue.pc       = pcF;
                issue.bImm     = bImm;
                issue.jImm     = jImm;
                issue.sImm     = sImm;
                chkValid       = 1'b1;
                group          = grpF;
                expAlu         = eAlu;
                expTgt         = eTgt;
                expMem         = eMem;
                expMis         = eMis;
            end
        end
        if (fd != 0)
            $fclose(fd);

        @(negedge clk);
        issue    = '0;
        chkValid = 1'b0;

        // drain pipe 5 and pipe 6
        waited = 0;
        while (ok && busy && waited < 20)
        begin
            @(posedge clk);
            waited++;
        end
        if (ok && busy)
        begin
            $display("Timeout while draining the pipeline");
            ok = 1'b0;
        end

        @(negedge clk);
        done   = 1'b1;
        waited = 0;
        while (ok && !reported && waited < 20)
        begin
            @(posedge clk);
            waited++;
        end
        if (ok && !reported)
        begin
            $display("Timeout while waiting for the monitor's last report");
            ok = 1'b0;
        end

        $display("%0d tests, %0d errors, %0d assertion failures",
                 tests, errors, uut.chk.failCount);
        if (ok && errors == 0 && uut.chk.failCount == 0)
        begin
            $display("Testbench passed");
        end
        else
        begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/exeMonitor.sv
`default_nettype none

module exeMonitor
(
    input  logic               clk,
    input  logic               chkValid,
    input  logic [3:0]         group,
    input  exePkg::issueBundle stim,
    input  exePkg::word        expAlu,
    input  exePkg::word        expTgt,
    input  exePkg::word        expMem,
    input  logic               expMis,
    input  exePkg::exeBundle   exe,
    input  exePkg::word        target,
    input  exePkg::word        memOut,
    input  logic               addrMisaligned,
    input  logic               done,
    output logic               busy,
    output logic               reported,
    output int                 errors,
    output int                 tests
);

    timeunit 1ns;
    timeprecision 1ps;

    // stage 1 lines up with pipe 5, stage 2 with pipe 6
    logic               v1 = 1'b0;
    logic               v2 = 1'b0;
    logic               doneR = 1'b0;
    logic [3:0]         grp1;
    logic [3:0]         grp2;
    logic [3:0]         curGrp = '0;
    exePkg::issueBundle s1;
    exePkg::word        a1;
    exePkg::word        t1;
    exePkg::word        m1;
    exePkg::word        m2;
    logic               mis1;
    logic               mis2;
    int                 grpErr [16];

    function automatic exePkg::word refAlu(exePkg::aluFn op, exePkg::word a, exePkg::word b);
        logic [4:0]  sh;
        exePkg::word fill;
        sh   = b[4:0];
        fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;   // sign bits for sra
        case (op)
            exePkg::ADD:   return a + b;
            exePkg::SUB:   return a + ~b + 32'd1;
            exePkg::SLL:   return a << sh;
            exePkg::SLT:   return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            exePkg::SLTU:  return {31'b0, a < b};
            exePkg::XOR:   return a ^ b;
            exePkg::SRL:   return a >> sh;
            exePkg::SRA:   return (a >> sh) | fill;
            exePkg::OR:    return a | b;
            exePkg::AND:   return a & b;
            exePkg::PASSB: return b;
            default:       return '0;
        endcase
    endfunction

    function automatic string groupName(logic [3:0] g);
        case (g)
            4'd1:    return "alu fixed";
            4'd2:    return "alu random";
            4'd3:    return "branch";
            4'd4:    return "jump";
            4'd5:    return "load/store";
            4'd6:    return "misaligned";
            default: return "unknown";
        endcase
    endfunction

    task automatic compare(string name, exePkg::word got, exePkg::word exp, logic [3:0] g);
        if (got !== exp)
        begin
            $display("Mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
            errors++;
            grpErr[g]++;
        end
    endtask

    task automatic closeGroup();
        if (curGrp != 0)
        begin
            $display("%s: %s (%0d errors)", groupName(curGrp),
                     (grpErr[curGrp] == 0) ? "ok" : "FAILED", grpErr[curGrp]);
            tests++;
        end
        curGrp = '0;
    endtask

    assign busy     = v1 | v2;
    assign reported = doneR && (curGrp == 0);

    always @(posedge clk)
    begin
        v1    <= chkValid;
        grp1  <= group;
        s1    <= stim;
        a1    <= (group == 4'd2) ? refAlu(stim.aluOp, stim.opA, stim.opB) : expAlu;
        t1    <= expTgt;
        m1    <= expMem;
        mis1  <= expMis;
        v2    <= v1;
        grp2  <= grp1;
        m2    <= m1;
        mis2  <= mis1;
        doneR <= done;
    end

    // outputs settled since the rising edge
    always @(negedge clk)
    begin
        if (v1)
        begin
            compare("aluRes", exe.aluRes, a1, grp1);
            compare("target", target, t1, grp1);
            compare("exe.rd", 32'(exe.rd), 32'(s1.rd), grp1);
            compare("exe.we", 32'(exe.we), 32'(s1.we), grp1);
            compare("exe.fn", 32'(exe.fn), 32'(s1.fn), grp1);
            compare("exe.pc", exe.pc, s1.pc, grp1);
            compare("exe.pcselect", 32'(exe.pcselect), 32'(s1.pcselect), grp1);
            compare("exe.j", 32'(exe.j), 32'(s1.j), grp1);
            compare("exe.jr", 32'(exe.jr), 32'(s1.jr), grp1);
        end
        if (v2)
        begin
            if (grp2 != curGrp)
            begin
                closeGroup();           // previous group has left pipe 6
                curGrp = grp2;
            end
            compare("memOut", memOut, m2, grp2);
            compare("addrMisaligned", 32'(addrMisaligned), 32'(mis2), grp2);
        end
        if (doneR)
            closeGroup();
    end

endmodule

`default_nettype wire

//--- sim/exeStage_checker.sv
`default_nettype none

module exeStageChecker
(
    input logic               clk,
    input logic               nrst,
    input exePkg::issueBundle issue,
    input exePkg::exeBundle   exe,
    input exePkg::word        target,
    input exePkg::word        memOut,
    input logic               addrMisaligned
);

    timeunit 1ns;
    timeprecision 1ps;

    int failCount = 0;

    resetClears: assert property (@(posedge clk)
        !nrst && $past(!nrst) |-> exe == '0 && memOut == '0 && !addrMisaligned)
        else
        begin
            $error("outputs not cleared while in reset");
            failCount++;
        end

    // first capture after release takes the idle bundle
    quietAfterReset: assert property (@(posedge clk)
        $rose(nrst) |=> !exe.we && !exe.j && !exe.jr && !addrMisaligned)
        else
        begin
            $error("controls active right after reset release");
            failCount++;
        end

    noFlagWithoutAccess: assert property (@(posedge clk) disable iff (!nrst)
        $past(issue.mOp, 2) == exePkg::NONE |-> !addrMisaligned)
        else
        begin
            $error("addrMisaligned raised for a cycle with no memory access");
            failCount++;
        end

    jalrTargetEven: assert property (@(posedge clk) disable iff (!nrst)
        $past(issue.jr) |-> !target[0])
        else
        begin
            $error("jalr target has bit 0 set");
            failCount++;
        end

endmodule

bind exeStage exeStageChecker chk
(
    .clk            (clk),
    .nrst           (nrst),
    .issue          (issue),
    .exe            (exe),
    .target         (target),
    .memOut         (memOut),
    .addrMisaligned (addrMisaligned)
);

`default_nettype wire

//--- rtl/exeStage.sv
`default_nettype none

module exeStage
(
    input  logic               clk,
    input  logic               nrst,
    input  exePkg::issueBundle issue,
    output exePkg::exeBundle   exe,
    output exePkg::word        target,
    output exePkg::word        memOut,
    output logic               addrMisaligned
);

    exePkg::issueBundle pipe5;
    exePkg::word        aluRes;
    logic               btaken;

    // pipe 5 register advances every cycle
    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            pipe5 <= '0;
        end
        else
        begin
            pipe5 <= issue;
        end
    end

    alu exeAlu
    (
        .aluOp  (pipe5.aluOp),
        .opA    (pipe5.opA),
        .opB    (pipe5.opB),
        .bneq   (pipe5.bneq),
        .btype  (pipe5.btype),
        .result (aluRes),
        .btaken (btaken)
    );

    branchUnit exeBu
    (
        .pc     (pipe5.pc),
        .opA    (pipe5.opA),
        .bImm   (pipe5.bImm),
        .jImm   (pipe5.jImm),
        .iImm   (pipe5.opB),        // I immediate rides in opB
        .btaken (btaken),
        .j      (pipe5.j),
        .jr     (pipe5.jr),
        .target (target)
    );

    // memory takes stage 4 values and registers them itself
    memWrap dmemWrap
    (
        .clk            (clk),
        .nrst           (nrst),
        .mOp            (issue.mOp),
        .fn             (issue.fn),
        .opA            (issue.opA),
        .opB            (issue.opB),
        .sImm           (issue.sImm),
        .memOut         (memOut),
        .addrMisaligned (addrMisaligned)
    );

    always_comb
    begin
        exe.we       = pipe5.we;
        exe.fn       = pipe5.fn;
        exe.rd       = pipe5.rd;
        exe.aluRes   = aluRes;
        exe.pc       = pipe5.pc;
        exe.pcselect = pipe5.pcselect;
        exe.j        = pipe5.j;
        exe.jr       = pipe5.jr;
    end

endmodule

`default_nettype wire

//--- rtl/memWrap.sv
`default_nettype none

module memWrap
(
    input  logic          clk,
    input  logic          nrst,
    input  exePkg::memOp  mOp,
    input  exePkg::funct3 fn,
    input  exePkg::word   opA,      // base address
    input  exePkg::word   opB,      // store data, load offset
    input  exePkg::word   sImm,     // store offset
    output exePkg::word   memOut,
    output logic          addrMisaligned
);

    exePkg::word   mem [0:exePkg::MEM_WORDS-1];

    exePkg::word   addr4;
    exePkg::word   addrR;
    exePkg::word   dataR;
    exePkg::funct3 fnR;
    exePkg::memOp  opR;

    logic [exePkg::MEM_AW-1:0] idx;
    logic        misaligned;
    logic        wrEn;
    logic [3:0]  byteEn;
    exePkg::word wrData;
    exePkg::word rdWord;
    exePkg::word shifted;
    exePkg::word loadData;

    // stores use the S immediate, loads the I immediate in opB
    assign addr4 = (mOp == exePkg::STORE) ? opA + sImm : opA + opB;

    // stage 4 access registered into pipe 5
    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            opR   <= exePkg::NONE;
            addrR <= '0;
            dataR <= '0;
            fnR   <= '0;
        end
        else
        begin
            opR   <= mOp;
            addrR <= addr4;
            dataR <= opB;
            fnR   <= fn;
        end
    end

    assign idx = addrR[exePkg::MEM_AW+1:2];     // wraps modulo memory size

    always_comb
    begin
        case (fnR[1:0])
            2'b01:   misaligned = addrR[0];
            2'b10:   misaligned = (addrR[1:0] != 2'b00);
            default: misaligned = 1'b0;
        endcase
        if (opR == exePkg::NONE)
            misaligned = 1'b0;
    end

    always_comb
    begin
        case (fnR[1:0])
            2'b00:
            begin
                byteEn = 4'b0001 << addrR[1:0];
                wrData = {4{dataR[7:0]}};
            end
            2'b01:
            begin
                byteEn = 4'b0011 << addrR[1:0];
                wrData = {2{dataR[15:0]}};
            end
            default:
            begin
                byteEn = 4'b1111;
                wrData = dataR;
            end
        endcase
    end

    assign wrEn = (opR == exePkg::STORE) && !misaligned;

    always_ff @(posedge clk)
    begin
        if (wrEn)
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (byteEn[i])
                    mem[idx][8*i +: 8] <= wrData[8*i +: 8];
            end
        end
    end

    // a store in the previous cycle is already visible here
    assign rdWord  = mem[idx];
    assign shifted = rdWord >> {addrR[1:0], 3'b000};

    always_comb
    begin
        case (fnR)
            exePkg::F3_B:  loadData = {{24{shifted[7]}}, shifted[7:0]};
            exePkg::F3_H:  loadData = {{16{shifted[15]}}, shifted[15:0]};
            exePkg::F3_BU: loadData = {24'b0, shifted[7:0]};
            exePkg::F3_HU: loadData = {16'b0, shifted[15:0]};
            default:       loadData = rdWord;
        endcase
    end

    // pipe 6
    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            memOut         <= '0;
            addrMisaligned <= 1'b0;
        end
        else
        begin
            memOut         <= (opR == exePkg::LOAD && !misaligned) ? loadData : '0;
            addrMisaligned <= misaligned;
        end
    end

endmodule

`default_nettype wire

//--- rtl/branchUnit.sv
`default_nettype none

module branchUnit
(
    input  exePkg::word pc,
    input  exePkg::word opA,
    input  exePkg::word bImm,
    input  exePkg::word jImm,
    input  exePkg::word iImm,
    input  logic        btaken,
    input  logic        j,
    input  logic        jr,
    output exePkg::word target
);

    exePkg::word base;
    exePkg::word offset;
    exePkg::word sum;

    // jalr wins over jal, jal over a taken branch
    always_comb
    begin
        base   = pc;
        offset = 32'd4;                     // sequential
        if (jr)
        begin
            base   = opA;
            offset = iImm;
        end
        else if (j)
            offset = jImm;
        else if (btaken)
            offset = bImm;
    end

    assign sum    = base + offset;
    assign target = {sum[31:1], sum[0] & ~jr};  // jalr drops bit 0

endmodule

`default_nettype wire

//--- rtl/alu.sv
`default_nettype none

module alu
(
    input  exePkg::aluFn aluOp,
    input  exePkg::word  opA,
    input  exePkg::word  opB,
    input  logic         bneq,
    input  logic         btype,
    output exePkg::word  result,
    output logic         btaken
);

    exePkg::word diff;
    logic        zero;
    logic [4:0]  shamt;

    assign diff  = opA - opB;
    assign zero  = (diff == '0);
    assign shamt = opB[4:0];

    // beq when bneq low, bne when high
    assign btaken = btype & (zero ^ bneq);

    always_comb
    begin
        case (aluOp)
            exePkg::ADD:
                result = opA + opB;
            exePkg::SUB:
                result = diff;
            exePkg::SLL:
                result = opA << shamt;
            exePkg::SLT:
                result = {31'b0, $signed(opA) < $signed(opB)};
            exePkg::SLTU:
                result = {31'b0, opA < opB};
            exePkg::XOR:
                result = opA ^ opB;
            exePkg::SRL:
                result = opA >> shamt;
            exePkg::SRA:
                result = $signed(opA) >>> shamt;    // keeps the sign bit
            exePkg::OR:
                result = opA | opB;
            exePkg::AND:
                result = opA & opB;
            exePkg::PASSB:
                result = opB;
            default:
                result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/exePkg.sv
`default_nettype none

package exePkg;

    // data, address and pc values
    typedef logic [31:0] word;
    typedef logic [4:0]  regAddr;
    typedef logic [2:0]  funct3;    // access width and sign in risc-v encoding
    typedef logic [1:0]  pcSel;     // next-pc source passed through only

    typedef enum logic [3:0]
    {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        PASSB                       // operand b straight through for lui
    } aluFn;

    typedef enum logic [1:0]
    {
        NONE, LOAD, STORE
    } memOp;

    // funct3 codes of the load/store widths
    localparam funct3 F3_B  = 3'b000;
    localparam funct3 F3_H  = 3'b001;
    localparam funct3 F3_W  = 3'b010;
    localparam funct3 F3_BU = 3'b100;
    localparam funct3 F3_HU = 3'b101;

    // data memory size
    localparam int MEM_WORDS = 256;
    localparam int MEM_AW    = $clog2(MEM_WORDS);

    typedef struct packed
    {
        logic   we;
        logic   bneq;
        logic   btype;
        logic   j;
        logic   jr;
        funct3  fn;
        regAddr rd;
        aluFn   aluOp;
        memOp   mOp;
        pcSel   pcselect;
        word    opA;
        word    opB;                // store data or the I immediate
        word    pc;
        word    bImm;
        word    jImm;
        word    sImm;
    } issueBundle;

    typedef struct packed
    {
        logic   we;
        funct3  fn;
        regAddr rd;
        word    aluRes;
        word    pc;
        pcSel   pcselect;
        logic   j;
        logic   jr;
    } exeBundle;

endpackage

`default_nettype wire
